// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := mips_core_tb
FILELIST := filelist.f

OBJ_DIR  := obj_dir
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
logic/mips_pkg.sv
logic/inst_if.sv
logic/ctrl_if.sv
logic/fetch_unit.sv
logic/control_decoder.sv
logic/register_file.sv
logic/alu.sv
logic/mem_writeback.sv
logic/mips_core.sv
sim/mips_core_tb.sv

// ==== logic/alu.sv ====
// ALU: add, sub, and, or, signed set-less-than, zero flag
`default_nettype none

module alu (
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  mips_pkg::alu_op_t op,
    output mips_pkg::word_t   result,
    output logic              zero
);

    logic less;

    // signed compare for slt
    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            mips_pkg::ALU_ADD: result = a + b;
            mips_pkg::ALU_SUB: result = a - b;
            mips_pkg::ALU_AND: result = a & b;
            mips_pkg::ALU_OR:  result = a | b;
            mips_pkg::ALU_SLT: result = {31'd0, less};
            default:           result = 32'd0;
        endcase
    end

    // whole result, used by beq
    assign zero = (result == 32'd0);

endmodule

`default_nettype wire

// ==== logic/control_decoder.sv ====
// main control and ALU operation decode from opcode and funct
`default_nettype none

module control_decoder (
    inst_if.dst inst,
    ctrl_if.src ctrl
);

    always_comb begin
        // everything off means no-op
        ctrl.reg_dst    = 1'b0;
        ctrl.alu_src    = 1'b0;
        ctrl.mem_to_reg = 1'b0;
        ctrl.reg_write  = 1'b0;
        ctrl.mem_read   = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.jump       = 1'b0;
        ctrl.jump_reg   = 1'b0;
        ctrl.link       = 1'b0;
        ctrl.alu_op     = mips_pkg::ALU_ADD;

        case (inst.opcode)
            mips_pkg::OP_RTYPE: begin
                case (inst.funct)
                    mips_pkg::FN_ADD: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = mips_pkg::ALU_ADD;
                    end
                    mips_pkg::FN_SUB: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = mips_pkg::ALU_SUB;
                    end
                    mips_pkg::FN_AND: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = mips_pkg::ALU_AND;
                    end
                    mips_pkg::FN_OR: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = mips_pkg::ALU_OR;
                    end
                    mips_pkg::FN_SLT: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = mips_pkg::ALU_SLT;
                    end
                    // jr only redirects the pc
                    mips_pkg::FN_JR: ctrl.jump_reg = 1'b1;
                    default: ;
                endcase
            end
            mips_pkg::OP_ADDI: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            mips_pkg::OP_LW: begin
                ctrl.alu_src    = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
            end
            mips_pkg::OP_SW: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            mips_pkg::OP_BEQ: begin
                // equality through a zero difference
                ctrl.branch = 1'b1;
                ctrl.alu_op = mips_pkg::ALU_SUB;
            end
            mips_pkg::OP_J: ctrl.jump = 1'b1;
            mips_pkg::OP_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: ;
        endcase
    end

    // a load and a store never share one instruction
    always_comb begin
        a_mem_exclusive : assert final (!(ctrl.mem_read && ctrl.mem_write))
            else $error("mem_read and mem_write both set, opcode %h", inst.opcode);
    end

endmodule

`default_nettype wire

// ==== logic/ctrl_if.sv ====
// interface for the control levels from the decoder
`default_nettype none

interface ctrl_if;

    logic                reg_dst;
    logic                alu_src;
    logic                mem_to_reg;
    logic                reg_write;
    logic                mem_read;
    logic                mem_write;
    logic                branch;
    logic                jump;
    logic                jump_reg;
    logic                link;
    mips_pkg::alu_op_t   alu_op;

    modport src (
        output reg_dst, alu_src, mem_to_reg, reg_write, mem_read, mem_write,
        output branch, jump, jump_reg, link, alu_op
    );

    // next-pc selection
    modport fetch (
        input branch, jump, jump_reg
    );

    // ALU operand and operation
    modport exec (
        input alu_src, alu_op
    );

    // memory strobes and register write-back
    modport wb (
        input reg_dst, mem_to_reg, reg_write, mem_read, mem_write, link
    );

endinterface

`default_nettype wire

// ==== logic/fetch_unit.sv ====
// pc register, next-pc selection and instruction field split
`default_nettype none

module fetch_unit #(
    parameter mips_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            rst_n,
    input  mips_pkg::word_t ir,
    input  mips_pkg::word_t rs_data,
    input  logic            zero,
    ctrl_if.fetch           ctrl,
    inst_if.src             inst,
    output mips_pkg::word_t pc,
    output mips_pkg::word_t pc_plus4
);

    mips_pkg::word_t branch_offset;
    mips_pkg::word_t branch_target;
    mips_pkg::word_t jump_target;
    mips_pkg::word_t next_pc;

    // ====================
    // field split
    // ====================
    assign inst.opcode = ir[31:26];
    assign inst.rs     = ir[25:21];
    assign inst.rt     = ir[20:16];
    assign inst.rd     = ir[15:11];
    assign inst.funct  = ir[5:0];
    assign inst.imm    = ir[15:0];
    assign inst.target = ir[25:0];

    // ====================
    // next pc
    // ====================
    assign pc_plus4 = pc + 32'd4;

    // sign-extended word offset
    assign branch_offset = {{14{ir[15]}}, ir[15:0], 2'b00};
    assign branch_target = pc_plus4 + branch_offset;
    assign jump_target   = {pc_plus4[31:28], inst.target, 2'b00};

    // jr wins over j, j over a taken beq
    always_comb begin
        if (ctrl.jump_reg) begin
            next_pc = rs_data;
        end else if (ctrl.jump) begin
            next_pc = jump_target;
        end else if (ctrl.branch && zero) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // word alignment must hold through jr targets and reset value
    a_pc_aligned : assert property (@(posedge clk) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

// ==== logic/inst_if.sv ====
// interface for the decoded instruction fields
`default_nettype none

interface inst_if;

    mips_pkg::opcode_t   opcode;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    mips_pkg::funct_t    funct;
    logic [15:0]         imm;
    // jump target before the shift by two
    logic [25:0]         target;

    // driven by the fetch side
    modport src (
        output opcode, rs, rt, rd, funct, imm, target
    );

    // read by decoder, register file and write-back
    modport dst (
        input opcode, rs, rt, rd, funct, imm, target
    );

endinterface

`default_nettype wire

// ==== logic/mem_writeback.sv ====
// data memory strobes and address, write-back destination and data select
`default_nettype none

module mem_writeback #(
    parameter int DMEM_ADDR_W = 7
) (
    ctrl_if.wb                     ctrl,
    inst_if.dst                    inst,
    input  mips_pkg::word_t        alu_result,
    input  mips_pkg::word_t        rt_data,
    input  mips_pkg::word_t        pc_plus4,
    input  mips_pkg::word_t        dmem_q,
    output logic                   dmem_cen,
    output logic                   dmem_wen,
    output logic [DMEM_ADDR_W-1:0] dmem_a,
    output mips_pkg::word_t        dmem_d,
    output logic                   wr_en,
    output mips_pkg::reg_addr_t    wr_addr,
    output mips_pkg::word_t        wr_data
);

    // ====================
    // data SRAM side
    // ====================
    // strobes are active low
    assign dmem_cen = !(ctrl.mem_read || ctrl.mem_write);
    assign dmem_wen = !ctrl.mem_write;
    // word address, byte offset dropped
    assign dmem_a   = alu_result[DMEM_ADDR_W+1:2];
    assign dmem_d   = rt_data;

    // ====================
    // register write-back
    // ====================
    assign wr_en = ctrl.reg_write;

    always_comb begin
        if (ctrl.reg_dst) begin
            wr_addr = inst.rd;
        end else if (ctrl.link) begin
            wr_addr = mips_pkg::LINK_REG;
        end else begin
            wr_addr = inst.rt;
        end
    end

    always_comb begin
        if (ctrl.link) begin
            wr_data = pc_plus4;
        end else if (ctrl.mem_to_reg) begin
            wr_data = dmem_q;
        end else begin
            wr_data = alu_result;
        end
    end

    always_comb begin
        a_wen_in_cen : assert final (dmem_wen || !dmem_cen)
            else $error("dmem write strobe without chip enable");
    end

endmodule

`default_nettype wire

// ==== logic/mips_core.sv ====
// single-cycle MIPS core top level with plain memory and observation ports
`default_nettype none

module mips_core #(
    parameter int              DMEM_ADDR_W = 7,
    parameter mips_pkg::word_t RESET_PC    = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mips_pkg::word_t        ir,
    input  mips_pkg::word_t        dmem_q,
    output mips_pkg::word_t        ir_addr,
    output logic                   dmem_cen,
    output logic                   dmem_wen,
    output logic [DMEM_ADDR_W-1:0] dmem_a,
    output mips_pkg::word_t        dmem_d,
    output logic                   rf_write,
    output mips_pkg::reg_addr_t    rf_waddr,
    output mips_pkg::word_t        rf_writedata
);

    inst_if inst ();
    ctrl_if ctrl ();

    mips_pkg::word_t     pc_plus4;
    mips_pkg::word_t     rs_data;
    mips_pkg::word_t     rt_data;
    mips_pkg::word_t     imm_ext;
    mips_pkg::word_t     alu_b;
    mips_pkg::word_t     alu_result;
    logic                alu_zero;
    logic                wr_en;
    mips_pkg::reg_addr_t wr_addr;
    mips_pkg::word_t     wr_data;

    // ====================
    // input side
    // ====================
    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .ir       (ir),
        .rs_data  (rs_data),
        .zero     (alu_zero),
        .ctrl     (ctrl),
        .inst     (inst),
        .pc       (ir_addr),
        .pc_plus4 (pc_plus4)
    );

    // ====================
    // processing
    // ====================
    control_decoder u_decoder (
        .inst (inst),
        .ctrl (ctrl)
    );

    register_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .inst    (inst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    // second operand: immediate for addi, lw, sw
    assign imm_ext = {{16{inst.imm[15]}}, inst.imm};
    assign alu_b   = ctrl.alu_src ? imm_ext : rt_data;

    alu u_alu (
        .a      (rs_data),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // ====================
    // output side
    // ====================
    mem_writeback #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) u_wb (
        .ctrl       (ctrl),
        .inst       (inst),
        .alu_result (alu_result),
        .rt_data    (rt_data),
        .pc_plus4   (pc_plus4),
        .dmem_q     (dmem_q),
        .dmem_cen   (dmem_cen),
        .dmem_wen   (dmem_wen),
        .dmem_a     (dmem_a),
        .dmem_d     (dmem_d),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    // observation copy of the write-back port
    assign rf_write     = wr_en;
    assign rf_waddr     = wr_addr;
    assign rf_writedata = wr_data;

endmodule

`default_nettype wire

// ==== logic/mips_pkg.sv ====
// word and field types, opcode and funct codes, ALU operation codes, link register
`default_nettype none

package mips_pkg;

    // ====================
    // basic types
    // ====================
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [3:0]  alu_op_t;

    // ====================
    // opcodes
    // ====================
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // R-type function codes
    localparam funct_t FN_JR  = 6'h08;
    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2a;

    // ====================
    // ALU operation select
    // ====================
    localparam alu_op_t ALU_AND = 4'b0000;
    localparam alu_op_t ALU_OR  = 4'b0001;
    localparam alu_op_t ALU_ADD = 4'b0010;
    localparam alu_op_t ALU_SUB = 4'b0110;
    localparam alu_op_t ALU_SLT = 4'b0111;

    // jal return address goes here
    localparam reg_addr_t LINK_REG = 5'd31;

endpackage

`default_nettype wire

// ==== logic/register_file.sv ====
// 32-entry register file, register 0 reads as zero
`default_nettype none

module register_file (
    input  logic                clk,
    input  logic                rst_n,
    inst_if.dst                 inst,
    input  logic                wr_en,
    input  mips_pkg::reg_addr_t wr_addr,
    input  mips_pkg::word_t     wr_data,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data
);

    // no storage behind register 0
    mips_pkg::word_t regs [1:31];

    // ====================
    // read ports
    // ====================
    assign rs_data = (inst.rs == 5'd0) ? 32'd0 : regs[inst.rs];
    assign rt_data = (inst.rt == 5'd0) ? 32'd0 : regs[inst.rt];

    // ====================
    // write port
    // ====================
    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            // writes to register 0 are dropped
            regs[wr_addr] <= wr_data;
        end
    end

    // destination comes from decoder and write-back mux
    a_waddr_known : assert property (
        @(posedge clk) disable iff (rst_n)
        wr_en |-> !$isunknown(wr_addr)
    ) else $error("register write with unknown address");

endmodule

`default_nettype wire

// ==== sim/mips_core_tb.sv ====
// testbench for the MIPS core: ROM and SRAM models, program table, reference model, checks
`default_nettype none

module mips_core_tb;

    localparam int CLK_PERIOD = 8;
    localparam int MAX_ROWS   = 32;

    // ====================
    // instruction encodings
    // ====================
    localparam logic [5:0] OPC_RTYPE = 6'h00;
    localparam logic [5:0] OPC_J     = 6'h02;
    localparam logic [5:0] OPC_JAL   = 6'h03;
    localparam logic [5:0] OPC_BEQ   = 6'h04;
    localparam logic [5:0] OPC_ADDI  = 6'h08;
    localparam logic [5:0] OPC_LW    = 6'h23;
    localparam logic [5:0] OPC_SW    = 6'h2b;
    localparam logic [5:0] OPC_BAD   = 6'h3f;
    localparam logic [5:0] FNC_JR    = 6'h08;
    localparam logic [5:0] FNC_ADD   = 6'h20;
    localparam logic [5:0] FNC_SUB   = 6'h22;
    localparam logic [5:0] FNC_AND   = 6'h24;
    localparam logic [5:0] FNC_OR    = 6'h25;
    localparam logic [5:0] FNC_SLT   = 6'h2a;
    localparam logic [5:0] FNC_BAD   = 6'h3f;

    logic                clk;
    logic                rst_n;
    mips_pkg::word_t     ir;
    mips_pkg::word_t     dmem_q;
    mips_pkg::word_t     ir_addr;
    logic                dmem_cen;
    logic                dmem_wen;
    logic [6:0]          dmem_a;
    mips_pkg::word_t     dmem_d;
    logic                rf_write;
    mips_pkg::reg_addr_t rf_waddr;
    mips_pkg::word_t     rf_writedata;

    // memory models and reference model state
    mips_pkg::word_t rom [0:255];
    logic            rom_used [0:255];
    mips_pkg::word_t dmem [0:127];
    mips_pkg::word_t m_mem [0:127];
    mips_pkg::word_t m_regs [0:31];
    mips_pkg::word_t m_pc;

    // program table with expected responses per row
    mips_pkg::word_t     row_instr [0:MAX_ROWS-1];
    string               row_name  [0:MAX_ROWS-1];
    mips_pkg::word_t     exp_pc    [0:MAX_ROWS-1];
    logic                exp_we    [0:MAX_ROWS-1];
    mips_pkg::reg_addr_t exp_waddr [0:MAX_ROWS-1];
    mips_pkg::word_t     exp_wdata [0:MAX_ROWS-1];
    logic                exp_cen   [0:MAX_ROWS-1];
    logic                exp_wen   [0:MAX_ROWS-1];
    logic [6:0]          exp_a     [0:MAX_ROWS-1];
    mips_pkg::word_t     exp_d     [0:MAX_ROWS-1];

    int     n_rows;
    int     error_count;
    int     check_count;
    integer seed;
    logic   table_ready = 1'b0;

    mips_core #(
        .DMEM_ADDR_W (7),
        .RESET_PC    (32'h0000_0000)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .ir           (ir),
        .dmem_q       (dmem_q),
        .ir_addr      (ir_addr),
        .dmem_cen     (dmem_cen),
        .dmem_wen     (dmem_wen),
        .dmem_a       (dmem_a),
        .dmem_d       (dmem_d),
        .rf_write     (rf_write),
        .rf_waddr     (rf_waddr),
        .rf_writedata (rf_writedata)
    );

    // 1 KB ROM, out-of-range pcs alias but fail the pc check
    assign ir     = rom[ir_addr[9:2]];
    assign dmem_q = dmem[dmem_a];

    always @(posedge clk) begin
        if (!rst_n && !dmem_cen && !dmem_wen) begin
            dmem[dmem_a] <= dmem_d;
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ====================
    // encoders and table
    // ====================
    function automatic mips_pkg::word_t enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                              input logic [4:0] rd, input logic [5:0] fn);
        return {OPC_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic mips_pkg::word_t enc_i(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mips_pkg::word_t enc_j(input logic [5:0] op, input logic [25:0] target);
        return {op, target};
    endfunction

    task automatic add_row(input mips_pkg::word_t instr, input string name);
        row_instr[n_rows] = instr;
        row_name[n_rows]  = name;
        n_rows++;
    endtask

    task automatic load_program();
        n_rows = 0;
        add_row(32'h0000_0000, "reset_nop");
        add_row(enc_i(OPC_ADDI, 5'd0, 5'd1, 16'd100), "addi_pos");
        add_row(enc_i(OPC_ADDI, 5'd0, 5'd2, 16'hfff9), "addi_neg");
        add_row(enc_r(5'd1, 5'd2, 5'd3, FNC_ADD), "add");
        add_row(enc_r(5'd2, 5'd1, 5'd4, FNC_SUB), "sub");
        add_row(enc_r(5'd1, 5'd3, 5'd5, FNC_AND), "and");
        add_row(enc_r(5'd1, 5'd2, 5'd6, FNC_OR), "or");
        add_row(enc_r(5'd2, 5'd1, 5'd7, FNC_SLT), "slt_true");
        add_row(enc_r(5'd1, 5'd2, 5'd8, FNC_SLT), "slt_false");
        add_row(enc_r(5'd1, 5'd1, 5'd0, FNC_ADD), "add_to_r0");
        add_row(enc_r(5'd0, 5'd1, 5'd9, FNC_ADD), "read_r0");
        add_row(enc_i(OPC_ADDI, 5'd0, 5'd10, 16'd64), "addi_base");
        add_row(enc_i(OPC_SW, 5'd10, 5'd4, 16'd8), "sw");
        add_row(enc_i(OPC_LW, 5'd10, 5'd11, 16'd8), "lw_after_sw");
        add_row(enc_i(OPC_LW, 5'd0, 5'd12, 16'd200), "lw_preset");
        add_row(enc_i(OPC_BEQ, 5'd1, 5'd9, 16'd3), "beq_taken");
        add_row(enc_i(OPC_BEQ, 5'd1, 5'd2, 16'd5), "beq_not_taken");
        add_row(enc_j(OPC_J, 26'h000_0040), "j");
        add_row(enc_j(OPC_JAL, 26'h000_0080), "jal");
        add_row(enc_i(OPC_ADDI, 5'd0, 5'd13, 16'h0300), "addi_jr_target");
        add_row(enc_r(5'd13, 5'd0, 5'd0, FNC_JR), "jr");
        add_row(enc_i(OPC_BAD, 5'd1, 5'd2, 16'h1234), "bad_opcode");
        add_row(enc_r(5'd1, 5'd2, 5'd14, FNC_BAD), "bad_funct");
        // r14 must still be zero after the no-op
        add_row(enc_r(5'd14, 5'd1, 5'd15, FNC_ADD), "after_nops");
        add_row(enc_r(5'd31, 5'd0, 5'd16, FNC_OR), "read_link");
    endtask

    task automatic preset_memories();
        seed = 62;
        for (int k = 0; k < 256; k++) begin
            // unknown opcode tagged with its word address
            rom[k]      = {OPC_BAD, 26'(k)};
            rom_used[k] = 1'b0;
        end
        for (int k = 0; k < 128; k++) begin
            dmem[k]  = $random(seed);
            m_mem[k] = dmem[k];
        end
    endtask

    // ====================
    // reference model
    // ====================
    task automatic model_step(input int i);
        mips_pkg::word_t instr;
        mips_pkg::word_t rsv;
        mips_pkg::word_t rtv;
        mips_pkg::word_t simm;
        mips_pkg::word_t pc4;
        mips_pkg::word_t addr;
        instr = row_instr[i];
        rsv   = m_regs[instr[25:21]];
        rtv   = m_regs[instr[20:16]];
        simm  = {{16{instr[15]}}, instr[15:0]};
        pc4   = m_pc + 32'd4;
        addr  = rsv + simm;
        exp_pc[i]    = m_pc;
        exp_we[i]    = 1'b0;
        exp_waddr[i] = instr[20:16];
        exp_wdata[i] = rsv + simm;
        exp_cen[i]   = 1'b1;
        exp_wen[i]   = 1'b1;
        exp_a[i]     = addr[8:2];
        exp_d[i]     = rtv;
        m_pc         = pc4;
        case (instr[31:26])
            OPC_RTYPE: begin
                exp_we[i]    = 1'b1;
                exp_waddr[i] = instr[15:11];
                case (instr[5:0])
                    FNC_ADD: exp_wdata[i] = rsv + rtv;
                    FNC_SUB: exp_wdata[i] = rsv - rtv;
                    FNC_AND: exp_wdata[i] = rsv & rtv;
                    FNC_OR:  exp_wdata[i] = rsv | rtv;
                    FNC_SLT: exp_wdata[i] = ($signed(rsv) < $signed(rtv)) ? 32'd1 : 32'd0;
                    FNC_JR: begin
                        exp_we[i] = 1'b0;
                        m_pc      = rsv;
                    end
                    default: exp_we[i] = 1'b0;
                endcase
            end
            OPC_ADDI: exp_we[i] = 1'b1;
            OPC_LW: begin
                exp_we[i]    = 1'b1;
                exp_cen[i]   = 1'b0;
                exp_wdata[i] = m_mem[addr[8:2]];
            end
            OPC_SW: begin
                exp_cen[i]        = 1'b0;
                exp_wen[i]        = 1'b0;
                m_mem[addr[8:2]] = rtv;
            end
            OPC_BEQ: begin
                if (rsv == rtv) begin
                    m_pc = pc4 + {simm[29:0], 2'b00};
                end
            end
            OPC_J: m_pc = {pc4[31:28], instr[25:0], 2'b00};
            OPC_JAL: begin
                m_pc         = {pc4[31:28], instr[25:0], 2'b00};
                exp_we[i]    = 1'b1;
                exp_waddr[i] = 5'd31;
                exp_wdata[i] = pc4;
            end
            default: ;
        endcase
        if (exp_we[i] && exp_waddr[i] != 5'd0) begin
            m_regs[exp_waddr[i]] = exp_wdata[i];
        end
    endtask

    // rows go into the ROM at the pc the model reaches them
    task automatic build_expected();
        int slot;
        for (int k = 0; k < 32; k++) begin
            m_regs[k] = 32'd0;
        end
        m_pc = 32'd0;
        for (int i = 0; i < n_rows; i++) begin
            slot = int'(m_pc[9:2]);
            if (m_pc[31:10] != 22'd0 || rom_used[slot]) begin
                error_count++;
                $display("program row %0d (%s) does not fit at pc %h", i, row_name[i], m_pc);
            end else begin
                rom[slot]      = row_instr[i];
                rom_used[slot] = 1'b1;
            end
            model_step(i);
        end
    endtask

    // ====================
    // checks
    // ====================
    task automatic check_value(input string what, input mips_pkg::word_t expected,
                               input mips_pkg::word_t actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("error %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    task automatic check_reset();
        check_value("reset ir_addr", 32'd0, ir_addr);
        check_value("reset rf_write", 32'd0, {31'd0, rf_write});
        check_value("reset dmem_cen", 32'd1, {31'd0, dmem_cen});
        check_value("reset dmem_wen", 32'd1, {31'd0, dmem_wen});
    endtask

    task automatic check_row(input int i);
        check_value({row_name[i], " ir_addr"}, exp_pc[i], ir_addr);
        check_value({row_name[i], " rf_write"}, {31'd0, exp_we[i]}, {31'd0, rf_write});
        if (exp_we[i]) begin
            check_value({row_name[i], " rf_waddr"}, {27'd0, exp_waddr[i]}, {27'd0, rf_waddr});
            check_value({row_name[i], " rf_writedata"}, exp_wdata[i], rf_writedata);
        end
        check_value({row_name[i], " dmem_cen"}, {31'd0, exp_cen[i]}, {31'd0, dmem_cen});
        check_value({row_name[i], " dmem_wen"}, {31'd0, exp_wen[i]}, {31'd0, dmem_wen});
        if (!exp_cen[i]) begin
            check_value({row_name[i], " dmem_a"}, {25'd0, exp_a[i]}, {25'd0, dmem_a});
        end
        if (!exp_wen[i]) begin
            check_value({row_name[i], " dmem_d"}, exp_d[i], dmem_d);
        end
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        rst_n       = 1'b1;
        error_count = 0;
        check_count = 0;
        preset_memories();
        load_program();
        build_expected();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_reset();
        @(posedge clk);
        #1 rst_n = 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            @(negedge clk);
            check_row(i);
            @(posedge clk);
        end
        #1;
        // final image must match the model after all stores
        for (int k = 0; k < 128; k++) begin
            check_value($sformatf("dmem[%0d]", k), m_mem[k], dmem[k]);
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog, one cycle per row plus margin
    initial begin
        wait (table_ready);
        #((n_rows + 40) * CLK_PERIOD);
        $display("timeout: run did not end within %0d cycles", n_rows + 40);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
